//--- Bender.yml
package:
  name: riscv_pipeline

sources:
  - files:
      - source/rv_pkg.sv
      - source/fetch_stage.sv
      - source/register_file.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_writeback.sv
      - source/riscv_pipeline.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_riscv_pipeline.sv

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     if_instr,
    input  rv_pkg::pc_t       if_pc,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              ex_reg_write,
    input  logic              mem_reg_write,
    input  rv_pkg::retire_t   retire,
    output logic              fetch_hold,
    output rv_pkg::id_ex_t    id_ex
);
    import rv_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    ctrl_t     ctrl;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      known_op;
    logic      use_rs2;
    logic      branch_ex;
    logic      data_stall;
    logic      bubble;

    // source still waiting on an older write
    function automatic logic pending(input reg_addr_t r);
        logic hit;
        hit = (ex_reg_write && r == ex_rd) || (mem_reg_write && r == mem_rd)
              || (retire.valid && r == retire.rd);
        return (r != '0) && hit;
    endfunction

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .retire   (retire),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        ctrl     = '0;
        known_op = 1'b1;
        case (opcode)
            opc_load: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            opc_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            opc_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_rtype  = 1'b1;
            end
            opc_branch: ctrl.branch = 1'b1;
            default: known_op = 1'b0;   // unknown words act as no-ops
        endcase
    end

    always_comb begin
        case (opcode)
            opc_store:  imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            opc_branch: imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                               if_instr[30:25], if_instr[11:8], 1'b0};
            default:    imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    assign use_rs2 = ctrl.is_rtype | ctrl.mem_write | ctrl.branch;

    // if/id still holds the branch that is now in ex, so it must not issue twice
    assign branch_ex  = id_ex.ctrl.branch;
    assign data_stall = known_op && !branch_ex
                        && (pending(rs1) || (use_rs2 && pending(rs2)));
    assign bubble     = data_stall || branch_ex;
    assign fetch_hold = data_stall || (ctrl.branch && !branch_ex);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (bubble) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{ctrl: ctrl, rs1_val: rs1_data, rs2_val: rs2_data, imm: imm,
                       pc: if_pc, rd: rd, funct3: if_instr[14:12],
                       funct7_5: if_instr[30]};
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::id_ex_t  id_ex,
    output logic            redirect,
    output rv_pkg::pc_t     redirect_pc,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    alu_op_t alu_op;
    word_t   alu_b;
    word_t   alu_result;
    logic    take;

    // alu control, only r-type looks at funct fields
    always_comb begin
        alu_op = alu_add;
        if (id_ex.ctrl.is_rtype) begin
            case (id_ex.funct3)
                3'b000:  alu_op = id_ex.funct7_5 ? alu_sub : alu_add;
                3'b111:  alu_op = alu_and;
                3'b110:  alu_op = alu_or;
                3'b100:  alu_op = alu_xor;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (alu_op)
            alu_add: alu_result = id_ex.rs1_val + alu_b;
            alu_sub: alu_result = id_ex.rs1_val - alu_b;
            alu_and: alu_result = id_ex.rs1_val & alu_b;
            alu_or:  alu_result = id_ex.rs1_val | alu_b;
            alu_xor: alu_result = id_ex.rs1_val ^ alu_b;
            default: alu_result = '0;
        endcase
    end

    // unsigned compares for lt and gt
    always_comb begin
        case (id_ex.funct3)
            3'b000:  take = (id_ex.rs1_val == id_ex.rs2_val);
            3'b001:  take = (id_ex.rs1_val != id_ex.rs2_val);
            3'b100:  take = (id_ex.rs1_val < id_ex.rs2_val);
            3'b101:  take = (id_ex.rs1_val > id_ex.rs2_val);
            default: take = 1'b0;
        endcase
    end

    assign redirect    = id_ex.ctrl.branch && take;
    assign redirect_pc = id_ex.pc + pc_t'($signed(id_ex.imm) >>> 2);   // byte offset to words

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{mem_read: id_ex.ctrl.mem_read, mem_write: id_ex.ctrl.mem_write,
                        reg_write: id_ex.ctrl.reg_write, alu_result: alu_result,
                        store_data: id_ex.rs2_val, rd: id_ex.rd};
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int imem_words = 64
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          imem_write,
    input  rv_pkg::pc_t   imem_addr,
    input  rv_pkg::word_t imem_data,
    input  logic          fetch_hold,
    input  logic          redirect,
    input  rv_pkg::pc_t   redirect_pc,
    output rv_pkg::word_t if_instr,
    output rv_pkg::pc_t   if_pc
);
    import rv_pkg::*;

    localparam int aw = $clog2(imem_words);

    word_t imem [imem_words];
    pc_t   pc_q;
    pc_t   fetch_pc;
    word_t fetch_word;

    // a taken branch fetches its target in the same cycle
    assign fetch_pc   = redirect ? redirect_pc : pc_q;
    assign fetch_word = imem[fetch_pc[aw-1:0]];

    always_ff @(posedge clk) begin
        if (imem_write) begin
            imem[imem_addr[aw-1:0]] <= imem_data;   // program load port
        end
    end

    // pc register and if/id
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_q     <= '0;
            if_instr <= '0;   // opcode 0 decodes as nothing
            if_pc    <= '0;
        end else if (!fetch_hold) begin
            pc_q     <= fetch_pc + pc_t'(1);
            if_instr <= fetch_word;
            if_pc    <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

//--- source/memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writeback #(
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::retire_t retire,
    output rv_pkg::store_t  store
);
    import rv_pkg::*;

    localparam int aw = $clog2(dmem_words);

    word_t dmem [dmem_words];
    word_t load_data;

    assign load_data = dmem[ex_mem.alu_result[aw-1:0]];   // address wraps at dmem_words

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin
            dmem[ex_mem.alu_result[aw-1:0]] <= ex_mem.store_data;
        end
    end

    // strobe in the same cycle as the write
    assign store = '{valid: ex_mem.mem_write, addr: ex_mem.alu_result,
                     data: ex_mem.store_data};

    // mem/wb
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire <= '0;
        end else begin
            retire.valid <= ex_mem.reg_write && (ex_mem.rd != '0);
            retire.rd    <= ex_mem.rd;
            retire.data  <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
        end
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::retire_t   retire,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31];   // no storage behind x0

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid) begin
            regs[retire.rd] <= retire.data;   // valid implies rd != 0
        end
    end

    // no write bypass, decode covers the wb stage
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline #(
    parameter int imem_words = 64,
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_write,
    input  rv_pkg::pc_t     imem_addr,
    input  rv_pkg::word_t   imem_data,
    output rv_pkg::retire_t retire,
    output rv_pkg::store_t  store
);
    import rv_pkg::*;

    word_t   if_instr;
    pc_t     if_pc;
    logic    fetch_hold;
    logic    redirect;
    pc_t     redirect_pc;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    fetch_stage #(
        .imem_words (imem_words)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .imem_write  (imem_write),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fetch_hold  (fetch_hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .if_instr    (if_instr),
        .if_pc       (if_pc)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset         (reset),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .ex_rd         (id_ex.rd),                 // producer in ex
        .mem_rd        (ex_mem.rd),                // producer in mem
        .ex_reg_write  (id_ex.ctrl.reg_write),
        .mem_reg_write (ex_mem.reg_write),
        .retire        (retire),
        .fetch_hold    (fetch_hold),
        .id_ex         (id_ex)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_writeback #(
        .dmem_words (dmem_words)
    ) u_mem_wb (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .retire (retire),
        .store  (store)
    );

endmodule

`default_nettype wire

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [xlen-1:0] pc_t;     // word address, not byte address
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      alu_op_t;

    localparam opcode_t opc_load   = 7'b0000011;
    localparam opcode_t opc_store  = 7'b0100011;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;

    localparam alu_op_t alu_add = 3'd0;
    localparam alu_op_t alu_sub = 3'd1;
    localparam alu_op_t alu_and = 3'd2;
    localparam alu_op_t alu_or  = 3'd3;
    localparam alu_op_t alu_xor = 3'd4;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic reg_write;
        logic branch;
        logic use_imm;   // alu operand b from immediate
        logic is_rtype;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        pc_t       pc;
        reg_addr_t rd;
        logic [2:0] funct3;
        logic      funct7_5;
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
    } store_t;

endpackage

`default_nettype wire

//--- verification/rv_encode.svh
`ifndef rv_encode_svh
`define rv_encode_svh

// instruction word builders, rv32i field layout

function automatic word_t addi_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opc_op_imm};
endfunction

function automatic word_t load_instr(input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, opc_load};   // lw
endfunction

function automatic word_t store_instr(input reg_addr_t rs2, input reg_addr_t rs1,
                                      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};   // sw
endfunction

function automatic word_t rtype_instr(input logic funct7_5, input logic [2:0] funct3,
                                      input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
    return {1'b0, funct7_5, 5'b00000, rs2, rs1, funct3, rd, opc_op};
endfunction

// offset counted in words, encoded as a byte offset
function automatic word_t branch_instr(input logic [2:0] funct3, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input int offset_words);
    logic [12:0] imm;
    imm = 13'(offset_words * 4);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opc_branch};
endfunction

`endif

//--- verification/tb_riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_pipeline;
    import rv_pkg::*;

    `include "rv_encode.svh"

    localparam int clk_period      = 20;
    localparam int imem_words      = 64;
    localparam int dmem_words      = 256;
    localparam int short_limit     = 40;   // cycles collected after reset release
    localparam int branch_limit    = 60;   // still well before the pc wraps imem
    localparam int limit_sum       = 4 * short_limit + branch_limit;
    localparam int watchdog_cycles = 5 * (imem_words + 6) + limit_sum + 200;
    localparam word_t nop_word     = 32'h0000_0013;   // addi x0, x0, 0

    logic    clk;
    logic    reset;
    logic    imem_write;
    pc_t     imem_addr;
    word_t   imem_data;
    retire_t retire;
    store_t  store;

    logic [15:0] lfsr = 16'd9479;
    word_t   prog [$];
    retire_t exp_retires [$];
    retire_t got_retires [$];
    store_t  exp_stores [$];
    store_t  got_stores [$];
    int      test_errors  = 0;
    int      total_errors = 0;
    int      tests_run    = 0;
    int      tests_failed = 0;

    riscv_pipeline #(
        .imem_words (imem_words),
        .dmem_words (dmem_words)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_write (imem_write),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .retire     (retire),
        .store      (store)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
    function automatic word_t random_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t sign_extend(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // unsigned compares for lt and gt
    function automatic logic branch_taken(input logic [2:0] funct3, input word_t a,
                                          input word_t b);
        case (funct3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return a < b;
            default: return a > b;
        endcase
    endfunction

    task automatic expect_retire(input reg_addr_t rd, input word_t data);
        exp_retires.push_back('{valid: 1'b1, rd: rd, data: data});
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_stores.push_back('{valid: 1'b1, addr: addr, data: data});
    endtask

    task automatic compare_strobes(input string name);
        int n;
        assert (got_retires.size() == exp_retires.size()) else begin
            $display("%s: %0d retire strobes arrived within the cycle limit, %0d expected",
                     name, got_retires.size(), exp_retires.size());
            test_errors++;
        end
        n = (got_retires.size() < exp_retires.size()) ? got_retires.size() : exp_retires.size();
        for (int i = 0; i < n; i++) begin
            assert (got_retires[i] == exp_retires[i]) else begin
                $display("Error at %0t: %s retire %0d wrote x%0d = %h, expected x%0d = %h",
                         $time, name, i, got_retires[i].rd, got_retires[i].data,
                         exp_retires[i].rd, exp_retires[i].data);
                test_errors++;
            end
        end
        assert (got_stores.size() == exp_stores.size()) else begin
            $display("%s: %0d store strobes arrived within the cycle limit, %0d expected",
                     name, got_stores.size(), exp_stores.size());
            test_errors++;
        end
        n = (got_stores.size() < exp_stores.size()) ? got_stores.size() : exp_stores.size();
        for (int i = 0; i < n; i++) begin
            assert (got_stores[i] == exp_stores[i]) else begin
                $display("Error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                         $time, name, i, got_stores[i].data, got_stores[i].addr,
                         exp_stores[i].data, exp_stores[i].addr);
                test_errors++;
            end
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
        test_errors = 0;
        prog.delete();
        exp_retires.delete();
        got_retires.delete();
        exp_stores.delete();
        got_stores.delete();
    endtask

    // reset, load imem under reset, release, then record strobes
    task automatic run_program(input string name, input int limit);
        @(posedge clk);
        reset      <= 1'b1;
        imem_write <= 1'b0;
        repeat (4) @(posedge clk);
        for (int a = 0; a < imem_words; a++) begin
            imem_write <= 1'b1;
            imem_addr  <= pc_t'(a);
            imem_data  <= (a < prog.size()) ? prog[a] : nop_word;
            @(negedge clk);
            assert (!retire.valid && !store.valid) else begin
                $display("%s: a strobe appeared while reset was held", name);
                test_errors++;
            end
            @(posedge clk);
        end
        imem_write <= 1'b0;
        reset      <= 1'b0;
        repeat (limit) begin
            @(negedge clk);
            if (retire.valid) got_retires.push_back(retire);
            if (store.valid) got_stores.push_back(store);
        end
        compare_strobes(name);
        report_test(name);
    endtask

    // x(i+1) = x(i) + imm, every step waits on the one before
    task automatic dependent_addi_chain();
        logic [11:0] imm;
        word_t       sum;
        sum = '0;
        for (int i = 0; i < 6; i++) begin
            imm = 12'(random_bits(12));
            sum = sum + sign_extend(imm);
            prog.push_back(addi_instr(reg_addr_t'(i + 1), reg_addr_t'(i), imm));
            expect_retire(reg_addr_t'(i + 1), sum);
        end
        run_program("addi chain", short_limit);
    endtask

    task automatic rtype_operations();
        logic [11:0] a_imm;
        logic [11:0] b_imm;
        word_t       a;
        word_t       b;
        word_t       result;
        logic [2:0]  f3_list [5] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100};
        a_imm = 12'(random_bits(12));
        b_imm = 12'(random_bits(12));
        a     = sign_extend(a_imm);
        b     = sign_extend(b_imm);
        prog.push_back(addi_instr(5'd1, 5'd0, a_imm));
        prog.push_back(addi_instr(5'd2, 5'd0, b_imm));
        expect_retire(5'd1, a);
        expect_retire(5'd2, b);
        // add sub and or xor into x3..x7
        for (int i = 0; i < 5; i++) begin
            prog.push_back(rtype_instr(i == 1, f3_list[i], reg_addr_t'(i + 3), 5'd1, 5'd2));
            case (i)
                0:       result = a + b;
                1:       result = a - b;
                2:       result = a & b;
                3:       result = a | b;
                default: result = a ^ b;
            endcase
            expect_retire(reg_addr_t'(i + 3), result);
        end
        run_program("r-type ops", short_limit);
    endtask

    task automatic store_then_load();
        logic [11:0] base;
        logic [11:0] off;
        logic [11:0] d1;
        logic [11:0] d2;
        word_t       addr;
        base = 12'(random_bits(9));
        off  = 12'(random_bits(6));
        d1   = 12'(random_bits(12));
        d2   = 12'(random_bits(12));
        addr = word_t'(base) + word_t'(off);
        prog.push_back(addi_instr(5'd1, 5'd0, base));
        prog.push_back(addi_instr(5'd2, 5'd0, d1));
        prog.push_back(addi_instr(5'd4, 5'd0, d2));
        prog.push_back(store_instr(5'd2, 5'd1, off));
        prog.push_back(store_instr(5'd4, 5'd1, off + 12'd1));   // neighbour word
        prog.push_back(load_instr(5'd5, 5'd1, off));
        prog.push_back(load_instr(5'd6, 5'd1, off + 12'd1));
        expect_retire(5'd1, word_t'(base));
        expect_retire(5'd2, sign_extend(d1));
        expect_retire(5'd4, sign_extend(d2));
        expect_retire(5'd5, sign_extend(d1));
        expect_retire(5'd6, sign_extend(d2));
        expect_store(addr, sign_extend(d1));
        expect_store(addr + 32'd1, sign_extend(d2));
        run_program("store and load", short_limit);
    endtask

    // x1 = a, x2 = all ones, x3 = a
    task automatic branch_outcomes();
        logic [9:0] a;
        word_t      vals [4];
        logic [2:0] f3_list [8] = '{3'b000, 3'b000, 3'b001, 3'b001,
                                    3'b100, 3'b100, 3'b101, 3'b101};
        int         rs1_list [8] = '{1, 1, 1, 1, 1, 2, 2, 1};
        int         rs2_list [8] = '{3, 2, 2, 3, 2, 1, 1, 3};
        a    = 10'(random_bits(10));
        vals = '{32'd0, word_t'(a), 32'hffff_ffff, word_t'(a)};
        prog.push_back(addi_instr(5'd1, 5'd0, 12'(a)));
        prog.push_back(addi_instr(5'd2, 5'd0, 12'hfff));   // largest unsigned value
        prog.push_back(addi_instr(5'd3, 5'd0, 12'(a)));
        expect_retire(5'd1, vals[1]);
        expect_retire(5'd2, vals[2]);
        expect_retire(5'd3, vals[3]);
        for (int i = 0; i < 8; i++) begin
            // jump over one addi onto the next
            prog.push_back(branch_instr(f3_list[i], reg_addr_t'(rs1_list[i]),
                                        reg_addr_t'(rs2_list[i]), 2));
            prog.push_back(addi_instr(reg_addr_t'(10 + i), 5'd0, 12'(i + 1)));
            prog.push_back(addi_instr(reg_addr_t'(20 + i), 5'd0, 12'(i + 101)));
            if (!branch_taken(f3_list[i], vals[rs1_list[i]], vals[rs2_list[i]])) begin
                expect_retire(reg_addr_t'(10 + i), word_t'(i + 1));
            end
            expect_retire(reg_addr_t'(20 + i), word_t'(i + 101));
        end
        run_program("branches", branch_limit);
    endtask

    task automatic x0_writes();
        logic [11:0] v1;
        logic [11:0] v2;
        v1 = 12'(random_bits(12)) | 12'd1;   // never zero
        v2 = 12'(random_bits(12));
        prog.push_back(addi_instr(5'd0, 5'd0, v1));
        prog.push_back(addi_instr(5'd5, 5'd0, v2));
        prog.push_back(addi_instr(5'd0, 5'd5, v1));
        prog.push_back(rtype_instr(1'b0, 3'b000, 5'd6, 5'd0, 5'd5));   // add x6, x0, x5
        prog.push_back(rtype_instr(1'b0, 3'b110, 5'd7, 5'd0, 5'd0));   // or x7, x0, x0
        expect_retire(5'd5, sign_extend(v2));
        expect_retire(5'd6, sign_extend(v2));
        expect_retire(5'd7, 32'd0);
        run_program("x0 writes", short_limit);
    endtask

    initial begin
        reset      = 1'b1;
        imem_write = 1'b0;
        imem_addr  = '0;
        imem_data  = '0;
        dependent_addi_chain();
        rtype_operations();
        store_then_load();
        branch_outcomes();
        x0_writes();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
source/rv_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/riscv_pipeline.sv
verification/tb_riscv_pipeline.sv
